// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rv_core_tb
FILELIST  := project.f
BUILD     := obj_dir
LOG       := sim.log

SIM  := $(BUILD)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -qx 'TEST OK' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== hw/rv_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_alu (
  input  rv_pkg::dec_bundle_t dec_i,
  output logic [`RV_XLEN-1:0] result_o,
  output logic [`RV_XLEN-1:0] next_pc_o
);

  import rv_pkg::*;

  logic [4:0]          shamt;
  logic                taken;
  logic [`RV_XLEN-1:0] target;

  assign shamt = dec_i.op2[4:0];

  always_comb begin
    case (dec_i.alu_op)
      `RV_ALU_ADD:  result_o = dec_i.op1 + dec_i.op2;
      `RV_ALU_SUB:  result_o = dec_i.op1 - dec_i.op2;
      `RV_ALU_SLL:  result_o = dec_i.op1 << shamt;
      `RV_ALU_SLT:  result_o = {31'd0, $signed(dec_i.op1) < $signed(dec_i.op2)};
      `RV_ALU_SLTU: result_o = {31'd0, dec_i.op1 < dec_i.op2};
      `RV_ALU_XOR:  result_o = dec_i.op1 ^ dec_i.op2;
      `RV_ALU_SRL:  result_o = dec_i.op1 >> shamt;
      `RV_ALU_SRA:  result_o = $unsigned($signed(dec_i.op1) >>> shamt);
      `RV_ALU_OR:   result_o = dec_i.op1 | dec_i.op2;
      `RV_ALU_AND:  result_o = dec_i.op1 & dec_i.op2;
      default:      result_o = dec_i.op1 + dec_i.op2;
    endcase
  end

  always_comb begin
    case (dec_i.alu_op[2:0])
      `RV_BR_BEQ:  taken = (dec_i.op1 == dec_i.op2);
      `RV_BR_BNE:  taken = (dec_i.op1 != dec_i.op2);
      `RV_BR_BLT:  taken = ($signed(dec_i.op1) < $signed(dec_i.op2));
      `RV_BR_BGE:  taken = ($signed(dec_i.op1) >= $signed(dec_i.op2));
      `RV_BR_BLTU: taken = (dec_i.op1 < dec_i.op2);
      `RV_BR_BGEU: taken = (dec_i.op1 >= dec_i.op2);
      default:     taken = 1'b0;
    endcase
  end

  // jbase is pc for jal and branches and rs1 for jalr.
  always_comb begin
    target    = dec_i.jbase + dec_i.imm;
    target[0] = 1'b0; // only jalr can produce an odd sum.
    if (dec_i.is_jump || (dec_i.is_branch && taken)) begin
      next_pc_o = target;
    end else begin
      next_pc_o = dec_i.pc + `RV_XLEN'(4);
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_decoder (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  rv_pkg::inst_u       in_inst_i,
  input  logic [`RV_XLEN-1:0] in_pc_i,
  output logic [4:0]          rs1_o,
  output logic [4:0]          rs2_o,
  input  logic [`RV_XLEN-1:0] rdata1_i,
  input  logic [`RV_XLEN-1:0] rdata2_i,
  input  rv_pkg::fwd_t        fwd_dec_i,
  input  rv_pkg::fwd_t        fwd_exe_i,
  output logic                dec_valid_o,
  input  logic                dec_ready_i,
  output rv_pkg::dec_bundle_t dec_o
);

  import rv_pkg::*;

  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] src1;
  logic [`RV_XLEN-1:0] src2;
  logic [2:0]          funct3;
  logic                f7_b5;
  dec_bundle_t         dec_d;
  dec_bundle_t         dec_q;
  logic                dec_valid_q;

  // the instruction in decode is younger than the one in execute, so it wins.
  function automatic logic [`RV_XLEN-1:0] fwd_sel(input logic [4:0]          addr,
                                                  input logic [`RV_XLEN-1:0] rf_data,
                                                  input fwd_t                dec_w,
                                                  input fwd_t                exe_w);
    logic [`RV_XLEN-1:0] val;
    val = rf_data;
    if (addr != 5'd0) begin
      if (dec_w.valid && (dec_w.rd == addr)) begin
        val = dec_w.data;
      end else if (exe_w.valid && (exe_w.rd == addr)) begin
        val = exe_w.data;
      end
    end
    return val;
  endfunction

  assign rs1_o  = in_inst_i.r.rs1;
  assign rs2_o  = in_inst_i.r.rs2;
  assign funct3 = in_inst_i.r.funct3;
  assign f7_b5  = in_inst_i.r.funct7[5];

  assign imm_i = {{20{in_inst_i.i.imm[11]}}, in_inst_i.i.imm};
  assign imm_b = {{19{in_inst_i.b.imm12}}, in_inst_i.b.imm12, in_inst_i.b.imm11,
                  in_inst_i.b.imm10_5, in_inst_i.b.imm4_1, 1'b0};
  assign imm_u = {in_inst_i.u.imm, 12'd0};
  assign imm_j = {{11{in_inst_i.j.imm20}}, in_inst_i.j.imm20, in_inst_i.j.imm19_12,
                  in_inst_i.j.imm11, in_inst_i.j.imm10_1, 1'b0};

  assign src1 = fwd_sel(rs1_o, rdata1_i, fwd_dec_i, fwd_exe_i);
  assign src2 = fwd_sel(rs2_o, rdata2_i, fwd_dec_i, fwd_exe_i);

  always_comb begin
    dec_d    = '0;
    dec_d.pc = in_pc_i;
    dec_d.rd = in_inst_i.r.rd;
    case (in_inst_i.r.opcode)
      `RV_OP_LUI: begin
        dec_d.op2 = imm_u; // op1 stays zero.
        dec_d.we  = 1'b1;
      end
      `RV_OP_AUIPC: begin
        dec_d.op1 = in_pc_i;
        dec_d.op2 = imm_u;
        dec_d.we  = 1'b1;
      end
      `RV_OP_JAL: begin
        dec_d.op1     = in_pc_i;
        dec_d.op2     = `RV_XLEN'(4); // link value.
        dec_d.jbase   = in_pc_i;
        dec_d.imm     = imm_j;
        dec_d.is_jump = 1'b1;
        dec_d.we      = 1'b1;
      end
      `RV_OP_JALR: begin
        dec_d.op1     = in_pc_i;
        dec_d.op2     = `RV_XLEN'(4);
        dec_d.jbase   = src1;
        dec_d.imm     = imm_i;
        dec_d.is_jump = 1'b1;
        dec_d.we      = 1'b1;
      end
      `RV_OP_BRANCH: begin
        dec_d.op1       = src1;
        dec_d.op2       = src2;
        dec_d.jbase     = in_pc_i;
        dec_d.imm       = imm_b;
        dec_d.alu_op    = {1'b0, funct3};
        dec_d.is_branch = 1'b1;
      end
      `RV_OP_OP_IMM: begin
        dec_d.op1    = src1;
        dec_d.op2    = imm_i;
        dec_d.alu_op = {(funct3 == `RV_F3_SR) ? f7_b5 : 1'b0, funct3}; // srai only.
        dec_d.we     = 1'b1;
      end
      `RV_OP_OP: begin
        dec_d.op1    = src1;
        dec_d.op2    = src2;
        dec_d.alu_op = {f7_b5, funct3};
        dec_d.we     = 1'b1;
      end
      default: begin
        dec_d.illegal = 1'b1;
      end
    endcase
    if (dec_d.rd == 5'd0) begin
      dec_d.we = 1'b0;
    end
  end

  // a new word is taken whenever the held one leaves in the same cycle.
  assign in_ready_o = !dec_valid_q || dec_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid_q <= 1'b0;
    end else if (in_ready_o) begin
      dec_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready_o && in_valid_i) begin
      dec_q <= dec_d;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_o       = dec_q;

endmodule

`default_nettype wire

// ==== hw/rv_exec_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_exec_core (
  input  logic                clk,
  input  logic                rst,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  input  rv_pkg::inst_u       in_inst_i,
  input  logic [`RV_XLEN-1:0] in_pc_i,
  output logic                out_valid_o,
  input  logic                out_ready_i,
  output rv_pkg::retire_t     out_rec_o
);

  import rv_pkg::*;

  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [`RV_XLEN-1:0] rdata1;
  logic [`RV_XLEN-1:0] rdata2;
  fwd_t                fwd_dec;
  fwd_t                fwd_exe;
  logic                dec_valid;
  logic                dec_ready;
  dec_bundle_t         dec_bundle;
  logic [`RV_XLEN-1:0] alu_result;
  logic [`RV_XLEN-1:0] alu_next_pc;
  logic                exe_valid_q;
  retire_t             exe_rec_q;
  logic                retire;

  rv_decoder dec_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_inst_i  (in_inst_i),
    .in_pc_i    (in_pc_i),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rdata1_i   (rdata1),
    .rdata2_i   (rdata2),
    .fwd_dec_i  (fwd_dec),
    .fwd_exe_i  (fwd_exe),
    .dec_valid_o(dec_valid),
    .dec_ready_i(dec_ready),
    .dec_o      (dec_bundle)
  );

  rv_alu alu_i (
    .dec_i    (dec_bundle),
    .result_o (alu_result),
    .next_pc_o(alu_next_pc)
  );

  rv_regfile rf_i (
    .clk     (clk),
    .rst     (rst),
    .raddr1_i(rs1),
    .raddr2_i(rs2),
    .rdata1_o(rdata1),
    .rdata2_o(rdata2),
    .we_i    (retire && exe_rec_q.we),
    .waddr_i (exe_rec_q.rd),
    .wdata_i (exe_rec_q.wdata)
  );

  assign retire    = exe_valid_q && out_ready_i;
  assign dec_ready = !exe_valid_q || out_ready_i; // empty or retiring this cycle.

  assign fwd_dec = '{valid: dec_valid && dec_bundle.we, rd: dec_bundle.rd, data: alu_result};
  assign fwd_exe = '{valid: exe_valid_q && exe_rec_q.we, rd: exe_rec_q.rd,
                     data: exe_rec_q.wdata};

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid_q <= 1'b0;
    end else if (dec_ready) begin
      exe_valid_q <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_ready && dec_valid) begin
      exe_rec_q <= '{pc: dec_bundle.pc, next_pc: alu_next_pc, rd: dec_bundle.rd,
                     wdata: alu_result, we: dec_bundle.we, illegal: dec_bundle.illegal};
    end
  end

  assign out_valid_o = exe_valid_q;
  assign out_rec_o   = exe_rec_q;

endmodule

`default_nettype wire

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one instruction word seen through every base format.
  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    b_fmt_t      b;
    u_fmt_t      u;
    j_fmt_t      j;
  } inst_u;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] op1;
    logic [`RV_XLEN-1:0] op2;
    logic [`RV_XLEN-1:0] jbase; // pc for jal and branches, rs1 for jalr.
    logic [`RV_XLEN-1:0] imm;
    logic [4:0]          rd;
    logic [3:0]          alu_op;
    logic                is_branch;
    logic                is_jump;
    logic                we;
    logic                illegal;
  } dec_bundle_t;

  typedef struct packed {
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] next_pc;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] wdata;
    logic                we;
    logic                illegal;
  } retire_t;

  typedef struct packed {
    logic                valid;
    logic [4:0]          rd;
    logic [`RV_XLEN-1:0] data;
  } fwd_t;

endpackage

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                rst,
  input  logic [4:0]          raddr1_i,
  input  logic [4:0]          raddr2_i,
  output logic [`RV_XLEN-1:0] rdata1_o,
  output logic [`RV_XLEN-1:0] rdata2_o,
  input  logic                we_i,
  input  logic [4:0]          waddr_i,
  input  logic [`RV_XLEN-1:0] wdata_i
);

  logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs[waddr_i] <= wdata_i; // x0 is never written.
    end
  end

  always_comb begin
    rdata1_o = (raddr1_i == 5'd0) ? '0 : regs[raddr1_i];
    rdata2_o = (raddr2_i == 5'd0) ? '0 : regs[raddr2_i];
  end

endmodule

`default_nettype wire

// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define RV_XLEN  32
`define RV_NREGS 32

// base opcodes handled by the core.
`define RV_OP_LUI    7'b0110111
`define RV_OP_AUIPC  7'b0010111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_OP_IMM 7'b0010011
`define RV_OP_OP     7'b0110011

// alu code is funct7[5] followed by funct3.
`define RV_ALU_ADD  4'b0000
`define RV_ALU_SUB  4'b1000
`define RV_ALU_SLL  4'b0001
`define RV_ALU_SLT  4'b0010
`define RV_ALU_SLTU 4'b0011
`define RV_ALU_XOR  4'b0100
`define RV_ALU_SRL  4'b0101
`define RV_ALU_SRA  4'b1101
`define RV_ALU_OR   4'b0110
`define RV_ALU_AND  4'b0111

// branch conditions, taken from funct3.
`define RV_BR_BEQ  3'b000
`define RV_BR_BNE  3'b001
`define RV_BR_BLT  3'b100
`define RV_BR_BGE  3'b101
`define RV_BR_BLTU 3'b110
`define RV_BR_BGEU 3'b111

// funct3 of the right shifts, where funct7[5] picks srl or sra.
`define RV_F3_SR 3'b101

`endif

// ==== project.f ====
+incdir+include
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_exec_core.sv
tests/rv_core_checker.sv
tests/rv_core_tb.sv

// ==== tests/rv_core_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_checker (
  input logic            clk,
  input logic            rst,
  input logic            in_ready_i,
  input logic            out_valid_i,
  input logic            out_ready_i,
  input rv_pkg::retire_t out_rec_i
);

  // a stalled record may not change or disappear.
  a_rec_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_rec_i))
    else $error("retire record changed while stalled");

  a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid_i)
    else $error("output valid right after reset");

  a_no_write: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && ((out_rec_i.rd == 5'd0) || out_rec_i.illegal) |-> !out_rec_i.we)
    else $error("write enable set for rd 0 or an illegal record");

  a_ready: assert property (@(posedge clk) disable iff (rst)
    !in_ready_i |-> out_valid_i && !out_ready_i)
    else $error("input not ready without an output stall");

endmodule

bind rv_exec_core rv_core_checker chk_i (
  .clk        (clk),
  .rst        (rst),
  .in_ready_i (in_ready_o),
  .out_valid_i(out_valid_o),
  .out_ready_i(out_ready_i),
  .out_rec_i  (out_rec_o)
);

`default_nettype wire

// ==== tests/rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_defs.svh"

module rv_core_tb;

  import rv_pkg::*;

  localparam int HALF        = 10;
  localparam int MAX_INSTR   = 200;
  localparam int WATCHDOG_NS = MAX_INSTR * 40 * 2 * HALF + 2000; // 40 cycles per instruction.

  logic        clk;
  logic        rst;
  logic        in_valid_i;
  logic        in_ready_o;
  inst_u       in_inst_i;
  logic [31:0] in_pc_i;
  logic        out_valid_o;
  logic        out_ready_i;
  retire_t     out_rec_o;
  logic [31:0] mregs [0:31];
  retire_t     exp_q [$];
  logic [31:0] pc;
  logic        stall_en;
  int          errors;
  int          tests;
  int          failed;

  rv_exec_core dut_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid_i (in_valid_i),
    .in_ready_o (in_ready_o),
    .in_inst_i  (in_inst_i),
    .in_pc_i    (in_pc_i),
    .out_valid_o(out_valid_o),
    .out_ready_i(out_ready_i),
    .out_rec_o  (out_rec_o)
  );

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests completed");
    $display("TEST FAILED");
    $finish;
  end

  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, $signed(a) < $signed(b)};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      default: return a >= b;
    endcase
  endfunction

  // executes one word on the register model and returns the record it should retire.
  function automatic retire_t model_exec(input logic [31:0] w, input logic [31:0] at_pc);
    retire_t     r;
    logic [31:0] a;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    a     = mregs[w[19:15]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_u = {w[31:12], 12'd0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    r         = '0;
    r.pc      = at_pc;
    r.next_pc = at_pc + 32'd4;
    r.rd      = w[11:7];
    r.we      = (w[11:7] != 5'd0);
    case (w[6:0])
      `RV_OP_LUI:    r.wdata = imm_u;
      `RV_OP_AUIPC:  r.wdata = at_pc + imm_u;
      `RV_OP_JAL: begin
        r.wdata   = at_pc + 32'd4;
        r.next_pc = at_pc + imm_j;
      end
      `RV_OP_JALR: begin
        r.wdata   = at_pc + 32'd4;
        r.next_pc = (a + imm_i) & ~32'd1;
      end
      `RV_OP_BRANCH: begin
        r.we = 1'b0;
        if (branch_taken(w[14:12], a, mregs[w[24:20]])) r.next_pc = at_pc + imm_b;
      end
      `RV_OP_OP_IMM: r.wdata = alu_ref(w[14:12], (w[14:12] == 3'b101) && w[30], a, imm_i);
      `RV_OP_OP:     r.wdata = alu_ref(w[14:12], w[30], a, mregs[w[24:20]]);
      default: begin
        r.we      = 1'b0;
        r.illegal = 1'b1;
      end
    endcase
    if (r.we) mregs[r.rd] = r.wdata;
    return r;
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
  endfunction

  // random op or op-imm word with registers up to rmax.
  function automatic logic [31:0] rand_alu(input int unsigned rmax);
    logic [2:0]  f3;
    logic        alt;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    f3  = 3'($urandom_range(0, 7));
    alt = 1'($urandom_range(0, 1));
    rd  = 5'($urandom_range(0, rmax));
    rs1 = 5'($urandom_range(0, rmax));
    rs2 = 5'($urandom_range(0, rmax));
    imm = 12'($urandom);
    if ((f3 != 3'b000) && (f3 != 3'b101)) alt = 1'b0;
    if ($urandom_range(0, 1) == 0) return enc_r({1'b0, alt, 5'd0}, rs2, rs1, f3, rd, `RV_OP_OP);
    if ((f3 == 3'b001) || (f3 == 3'b101)) imm = {1'b0, (f3 == 3'b101) && alt, 5'd0, imm[4:0]};
    return enc_i(imm, rs1, f3, rd, `RV_OP_OP_IMM);
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp,
                           input logic [31:0] at_pc);
    if (got !== exp) begin
      $display("mismatch %s at pc 0x%08h: got 0x%08h, expected 0x%08h", name, at_pc, got, exp);
      errors++;
    end
  endtask

  // drives out_ready_i and checks every retired record just before the rising edge.
  initial begin : monitor
    retire_t held_rec;
    retire_t exp;
    logic    held;
    held     = 1'b0;
    held_rec = '0;
    forever begin
      @(negedge clk);
      out_ready_i = !stall_en || ($urandom_range(0, 2) != 0);
      #(HALF - 1);
      if (!rst) begin
        if (held && (!out_valid_o || (out_rec_o !== held_rec))) begin
          $display("retire record at pc 0x%08h changed while stalled", held_rec.pc);
          errors++;
        end
        if (!in_ready_o && !(out_valid_o && !out_ready_i)) begin
          $display("input handshake not ready although the output is not stalled");
          errors++;
        end
        held     = out_valid_o && !out_ready_i;
        held_rec = out_rec_o;
        if (out_valid_o && out_ready_i) begin
          if (exp_q.size() == 0) begin
            $display("a record retired with no instruction outstanding");
            errors++;
          end else begin
            exp = exp_q.pop_front();
            check_val("out_rec_o.pc", out_rec_o.pc, exp.pc, exp.pc);
            check_val("out_rec_o.next_pc", out_rec_o.next_pc, exp.next_pc, exp.pc);
            check_val("out_rec_o.we", 32'(out_rec_o.we), 32'(exp.we), exp.pc);
            check_val("out_rec_o.illegal", 32'(out_rec_o.illegal), 32'(exp.illegal), exp.pc);
            if (exp.we) begin
              check_val("out_rec_o.rd", 32'(out_rec_o.rd), 32'(exp.rd), exp.pc);
              check_val("out_rec_o.wdata", out_rec_o.wdata, exp.wdata, exp.pc);
            end
          end
        end
      end
    end
  end

  task automatic issue(input logic [31:0] w);
    int n;
    exp_q.push_back(model_exec(w, pc));
    @(negedge clk);
    in_valid_i    = 1'b1;
    in_inst_i.raw = w;
    in_pc_i       = pc;
    pc            = pc + 32'd4; // fetch is not modelled, so words are simply sequential.
    n             = 0;
    #(HALF - 1);
    while (!in_ready_o && (n < 100)) begin
      @(negedge clk);
      #(HALF - 1);
      n++;
    end
    if (!in_ready_o) begin
      $display("instruction at pc 0x%08h was never accepted", in_pc_i);
      errors++;
    end
  endtask

  task automatic drain();
    int n;
    @(negedge clk);
    in_valid_i = 1'b0;
    n          = 0;
    while ((exp_q.size() != 0) && (n < 200)) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d instructions never retired", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  task automatic load_reg(input logic [4:0] rd, input logic [31:0] val);
    logic [31:0] hi;
    hi = val + 32'h800; // the addi below sign-extends its immediate.
    issue({hi[31:12], rd, `RV_OP_LUI});
    issue(enc_i(val[11:0], rd, 3'b000, rd, `RV_OP_OP_IMM));
  endtask

  task automatic report(input string name, input int err_before);
    tests++;
    if (errors != err_before) begin
      failed++;
      $display("%s: failed with %0d errors", name, errors - err_before);
    end else begin
      $display("%s: passed", name);
    end
  endtask

  task automatic test_reset();
    int e;
    e = errors;
    #(HALF - 1);
    check_val("out_valid_o", 32'(out_valid_o), 32'd0, 32'd0);
    check_val("in_ready_o", 32'(in_ready_o), 32'd1, 32'd0);
    report("reset", e);
  endtask

  task automatic test_arith();
    int e;
    e = errors;
    for (int r = 1; r <= 8; r++) load_reg(5'(r), $urandom);
    repeat (30) issue(rand_alu(8));
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd9, `RV_OP_OP)); // sub.
    issue(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd10, `RV_OP_OP)); // sra.
    issue(enc_i({7'h20, 5'd7}, 5'd1, 3'b101, 5'd11, `RV_OP_OP_IMM)); // srai.
    issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0, `RV_OP_OP));
    issue(enc_i(12'd0, 5'd0, 3'b000, 5'd12, `RV_OP_OP_IMM));
    drain();
    report("arith", e);
  endtask

  task automatic test_chain();
    int e;
    e = errors;
    load_reg(5'd10, $urandom);
    load_reg(5'd11, $urandom);
    for (int i = 2; i < 18; i++) begin
      issue(enc_r({1'b0, 1'($urandom_range(0, 1)), 5'd0}, 5'(10 + (i - 2) % 8),
                  5'(10 + (i - 1) % 8), 3'b000, 5'(10 + i % 8), `RV_OP_OP));
    end
    drain();
    report("chain", e);
  endtask

  task automatic test_control();
    int          e;
    logic [31:0] pos;
    logic [31:0] neg;
    e = errors;
    issue({20'($urandom), 5'd5, `RV_OP_LUI});
    issue({20'($urandom), 5'd6, `RV_OP_AUIPC});
    issue(enc_j(21'($urandom) & ~21'd1, 5'd1));
    issue(enc_j(-21'sd8, 5'd0));
    load_reg(5'd7, $urandom);
    issue(enc_i(12'($urandom), 5'd7, 3'b000, 5'd8, `RV_OP_JALR));
    issue(enc_i(12'd5, 5'd7, 3'b000, 5'd7, `RV_OP_JALR));
    for (int p = 0; p < 3; p++) begin
      pos = $urandom & 32'h7fff_ffff;
      neg = $urandom | 32'h8000_0000;
      load_reg(5'd20, (p == 1) ? neg : pos); // equal, signed less, unsigned less.
      load_reg(5'd21, (p == 2) ? neg : pos);
      for (int f = 0; f < 8; f++) begin
        if ((f != 2) && (f != 3)) issue(enc_b(13'($urandom) & ~13'd1, 5'd21, 5'd20, 3'(f)));
      end
    end
    drain();
    report("control", e);
  endtask

  task automatic test_backpressure();
    int e;
    e        = errors;
    stall_en = 1'b1;
    for (int r = 1; r <= 3; r++) load_reg(5'(r), $urandom);
    repeat (34) issue(rand_alu(5));
    drain();
    stall_en = 1'b0;
    report("backpressure", e);
  endtask

  task automatic test_illegal();
    int e;
    e = errors;
    load_reg(5'd5, $urandom);
    issue(enc_i(12'h010, 5'd1, 3'b010, 5'd5, 7'b0000011)); // lw.
    issue(enc_r(7'h00, 5'd5, 5'd1, 3'b010, 5'd4, 7'b0100011)); // sw.
    issue(enc_i(12'h300, 5'd1, 3'b001, 5'd5, 7'b1110011)); // csrrw.
    issue(enc_i(12'd0, 5'd5, 3'b000, 5'd6, `RV_OP_OP_IMM));
    drain();
    report("illegal", e);
  endtask

  initial begin
    void'($urandom(36));
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    in_inst_i   = '0;
    in_pc_i     = '0;
    out_ready_i = 1'b1;
    stall_en    = 1'b0;
    pc          = 32'h0000_1000;
    errors      = 0;
    tests       = 0;
    failed      = 0;
    for (int k = 0; k < 32; k++) mregs[k] = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_arith();
    test_chain();
    test_control();
    test_backpressure();
    test_illegal();
    $display("summary: %0d tests run, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
